// ==== logic/bus_pkg.sv ====
package bus_pkg;

  // bus widths
  localparam int ADDR_W = 32;
  localparam int DATA_W = 32;
  localparam int ID_W   = 4;
  localparam int SIZE_W = 3;
  localparam int RESP_W = 2;

  // requesters, 0 is fetch and 1 is load
  localparam int N_MASTERS = 2;
  localparam int MST_IDX_W = (N_MASTERS > 1) ? $clog2(N_MASTERS) : 1;

  // core-local timer window
  localparam logic [ADDR_W-1:0] CLINT_BASE   = 32'h0200_0000;
  localparam logic [ADDR_W-1:0] CLINT_SIZE   = 32'h0001_0000; // 64 KiB
  localparam logic [ADDR_W-1:0] MTIME_LO_OFF = 32'h0000_bff8;
  localparam logic [ADDR_W-1:0] MTIME_HI_OFF = 32'h0000_bffc;
  localparam int                MTIME_W      = 64;

  // read response codes
  localparam logic [RESP_W-1:0] RESP_OKAY   = 2'd0;
  localparam logic [RESP_W-1:0] RESP_DECERR = 2'd3;

  // single-beat read request, 39 bits
  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [ID_W-1:0]   id;
    logic [SIZE_W-1:0] size;
  } rd_req_t;

  // read response beat, 39 bits
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [RESP_W-1:0] resp;
    logic              last;
    logic [ID_W-1:0]   id;
  } rd_rsp_t;

endpackage

// ==== logic/hold_slice.sv ====
module hold_slice #(
  parameter type payload_t = logic
) (
  input  logic     clock,
  input  logic     rst_n,
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  logic     full;
  payload_t data_q;

  // take a new item when empty or when the held one leaves this cycle
  assign in_ready  = !full || out_ready;
  assign out_valid = full;
  assign out_data  = data_q;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      full <= 1'b0;
    end else if (in_valid && in_ready) begin
      full <= 1'b1;
    end else if (out_ready) begin
      full <= 1'b0; // drained, nothing new
    end
  end

  always_ff @(posedge clock) begin
    if (in_valid && in_ready) begin
      data_q <= in_data;
    end
  end

  // a stalled item must not change under the consumer
  a_out_stable: assert property (
    @(posedge clock) disable iff (!rst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_data))
  ) else $error("hold_slice: out_data changed while stalled");

endmodule

// ==== logic/read_arbiter.sv ====
module read_arbiter (
  input  logic                               clock,
  input  logic                               rst_n,
  // drained request slices
  input  logic [bus_pkg::N_MASTERS-1:0]      slice_valid,
  output logic [bus_pkg::N_MASTERS-1:0]      slice_ready,
  input  bus_pkg::rd_req_t                   slice_req [bus_pkg::N_MASTERS],
  // responses back to the masters
  output logic [bus_pkg::N_MASTERS-1:0]      rsp_valid,
  input  logic [bus_pkg::N_MASTERS-1:0]      rsp_ready,
  output bus_pkg::rd_rsp_t                   rsp [bus_pkg::N_MASTERS],
  // external memory
  output logic                               ext_ar_valid,
  input  logic                               ext_ar_ready,
  output bus_pkg::rd_req_t                   ext_ar,
  input  logic                               ext_r_valid,
  output logic                               ext_r_ready,
  input  bus_pkg::rd_rsp_t                   ext_r,
  // timer
  output logic                               clint_ar_valid,
  input  logic                               clint_ar_ready,
  output bus_pkg::rd_req_t                   clint_ar,
  input  logic                               clint_r_valid,
  output logic                               clint_r_ready,
  input  bus_pkg::rd_rsp_t                   clint_r
);

  import bus_pkg::*;

  logic                 busy;       // one read in flight
  logic [MST_IDX_W-1:0] grant_idx;  // owner of the read in flight
  logic                 tgt_clint;  // its target

  logic                 req_any;
  logic [MST_IDX_W-1:0] sel_idx;
  rd_req_t              sel_req;
  logic                 sel_clint;
  logic                 sel_ready;
  logic                 ar_fire;

  rd_rsp_t              r_mux;
  logic                 r_valid_mux;
  logic                 rsp_fire;
  logic                 rsp_done;
  logic                 can_grant;

  // fixed priority, the highest valid index wins
  always_comb begin
    req_any = 1'b0;
    sel_idx = '0;
    for (int i = 0; i < N_MASTERS; i++) begin
      if (slice_valid[i]) begin
        req_any = 1'b1;
        sel_idx = MST_IDX_W'(i);
      end
    end
  end

  assign sel_req   = slice_req[sel_idx];
  assign sel_clint = (sel_req.addr >= CLINT_BASE) &&
                     (sel_req.addr < CLINT_BASE + CLINT_SIZE);

  // response side, steered by the recorded grant
  assign r_valid_mux = tgt_clint ? clint_r_valid : ext_r_valid;
  assign r_mux       = tgt_clint ? clint_r : ext_r;
  assign rsp_fire    = busy && r_valid_mux && rsp_ready[grant_idx];
  assign rsp_done    = rsp_fire && r_mux.last;

  // a new grant may go out in the cycle the last beat returns
  assign can_grant = !busy || rsp_done;

  assign ext_ar_valid   = can_grant && req_any && !sel_clint;
  assign clint_ar_valid = can_grant && req_any && sel_clint;
  assign ext_ar         = sel_req;
  assign clint_ar       = sel_req;

  assign sel_ready = sel_clint ? clint_ar_ready : ext_ar_ready;
  assign ar_fire   = can_grant && req_any && sel_ready;

  always_comb begin
    for (int i = 0; i < N_MASTERS; i++) begin
      slice_ready[i] = ar_fire && (sel_idx == MST_IDX_W'(i));
      rsp_valid[i]   = busy && r_valid_mux && (grant_idx == MST_IDX_W'(i));
      rsp[i]         = r_mux; // only the owner sees valid
    end
  end

  assign ext_r_ready   = busy && !tgt_clint && rsp_ready[grant_idx];
  assign clint_r_ready = busy && tgt_clint && rsp_ready[grant_idx];

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      busy      <= 1'b0;
      grant_idx <= '0;
      tgt_clint <= 1'b0;
    end else if (ar_fire) begin
      busy      <= 1'b1;
      grant_idx <= sel_idx;
      tgt_clint <= sel_clint;
    end else if (rsp_done) begin
      busy <= 1'b0;
    end
  end

  // never address both targets at once
  a_one_target: assert property (
    @(posedge clock) disable iff (!rst_n)
    $onehot0({ext_ar_valid, clint_ar_valid})
  ) else $error("read_arbiter: request sent to both targets");

  // targets only answer reads that were granted
  a_no_rsp_idle: assert property (
    @(posedge clock) disable iff (!rst_n)
    !busy |-> !(ext_r_valid || clint_r_valid)
  ) else $error("read_arbiter: response with no read outstanding");

endmodule

// ==== logic/clint_timer.sv ====
module clint_timer (
  input  logic             clock,
  input  logic             rst_n,
  input  logic             ar_valid,
  output logic             ar_ready,
  input  bus_pkg::rd_req_t ar,
  output logic             r_valid,
  input  logic             r_ready,
  output bus_pkg::rd_rsp_t r
);

  import bus_pkg::*;

  logic [MTIME_W-1:0] mtime;
  logic [ADDR_W-1:0]  offset;
  rd_rsp_t            rsp_next;

  // free-running, one tick per clock
  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 1'b1;
    end
  end

  assign offset = ar.addr - CLINT_BASE;

  always_comb begin
    rsp_next.last = 1'b1; // single beat
    rsp_next.id   = ar.id;
    if (offset == MTIME_LO_OFF) begin
      rsp_next.data = mtime[DATA_W-1:0];
      rsp_next.resp = RESP_OKAY;
    end else if (offset == MTIME_HI_OFF) begin
      rsp_next.data = mtime[MTIME_W-1:DATA_W];
      rsp_next.resp = RESP_OKAY;
    end else begin
      // nothing else is mapped in the window
      rsp_next.data = '0;
      rsp_next.resp = RESP_DECERR;
    end
  end

  // response slice sets the one-cycle latency and the back-pressure
  hold_slice #(
    .payload_t (rd_rsp_t)
  ) rsp_slice_i (
    .clock     (clock),
    .rst_n     (rst_n),
    .in_valid  (ar_valid),
    .in_ready  (ar_ready),
    .in_data   (rsp_next),
    .out_valid (r_valid),
    .out_ready (r_ready),
    .out_data  (r)
  );

endmodule

// ==== logic/read_fabric.sv ====
module read_fabric (
  input  logic                          clock,
  input  logic                          rst_n,
  // requesters, 0 fetch and 1 load
  input  logic [bus_pkg::N_MASTERS-1:0] req_valid,
  output logic [bus_pkg::N_MASTERS-1:0] req_ready,
  input  bus_pkg::rd_req_t              req [bus_pkg::N_MASTERS],
  output logic [bus_pkg::N_MASTERS-1:0] rsp_valid,
  input  logic [bus_pkg::N_MASTERS-1:0] rsp_ready,
  output bus_pkg::rd_rsp_t              rsp [bus_pkg::N_MASTERS],
  // external AXI read master
  output logic                          ext_ar_valid,
  input  logic                          ext_ar_ready,
  output bus_pkg::rd_req_t              ext_ar,
  input  logic                          ext_r_valid,
  output logic                          ext_r_ready,
  input  bus_pkg::rd_rsp_t              ext_r
);

  import bus_pkg::*;

  logic [N_MASTERS-1:0] slice_valid;
  logic [N_MASTERS-1:0] slice_ready;
  rd_req_t              slice_req [N_MASTERS];

  logic    clint_ar_valid;
  logic    clint_ar_ready;
  rd_req_t clint_ar;
  logic    clint_r_valid;
  logic    clint_r_ready;
  rd_rsp_t clint_r;

  // one request slot per master
  for (genvar m = 0; m < N_MASTERS; m++) begin : g_req_slice
    hold_slice #(
      .payload_t (rd_req_t)
    ) req_slice_i (
      .clock     (clock),
      .rst_n     (rst_n),
      .in_valid  (req_valid[m]),
      .in_ready  (req_ready[m]),
      .in_data   (req[m]),
      .out_valid (slice_valid[m]),
      .out_ready (slice_ready[m]),
      .out_data  (slice_req[m])
    );
  end

  read_arbiter read_arbiter_i (
    .clock          (clock),
    .rst_n          (rst_n),
    .slice_valid    (slice_valid),
    .slice_ready    (slice_ready),
    .slice_req      (slice_req),
    .rsp_valid      (rsp_valid),
    .rsp_ready      (rsp_ready),
    .rsp            (rsp),
    .ext_ar_valid   (ext_ar_valid),
    .ext_ar_ready   (ext_ar_ready),
    .ext_ar         (ext_ar),
    .ext_r_valid    (ext_r_valid),
    .ext_r_ready    (ext_r_ready),
    .ext_r          (ext_r),
    .clint_ar_valid (clint_ar_valid),
    .clint_ar_ready (clint_ar_ready),
    .clint_ar       (clint_ar),
    .clint_r_valid  (clint_r_valid),
    .clint_r_ready  (clint_r_ready),
    .clint_r        (clint_r)
  );

  clint_timer clint_timer_i (
    .clock    (clock),
    .rst_n    (rst_n),
    .ar_valid (clint_ar_valid),
    .ar_ready (clint_ar_ready),
    .ar       (clint_ar),
    .r_valid  (clint_r_valid),
    .r_ready  (clint_r_ready),
    .r        (clint_r)
  );

endmodule

// ==== tests/fabric_tests.svh ====
// compare one observed value with its expected value
task automatic check_value(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
  checks++;
  if (expected !== actual) begin
    errors++;
    $display("CHECK FAILED: %s expected 0x%0h actual 0x%0h", name, expected, actual);
  end
endtask

task automatic clear_logs();
  ar_log.delete();
  rsp_log.delete();
  rsp_mst.delete();
endtask

// present a word read on one master without waiting
task automatic set_req(input int m, input logic [ADDR_W-1:0] addr,
                       input logic [ID_W-1:0] id);
  req[m].addr  = addr;
  req[m].id    = id;
  req[m].size  = 3'd2;
  req_valid[m] = 1'b1;
endtask

// drop each raised req_valid once its slice took it
task automatic wait_accepted(output int accept_cycle);
  logic [N_MASTERS-1:0] taken;
  int                   guard;
  accept_cycle = 0;
  guard        = 0;
  while (req_valid != '0 && guard < 50) begin
    @(posedge clock);
    taken = req_valid & req_ready;
    if (taken != '0) begin
      accept_cycle = cycle_cnt;
    end
    @(negedge clock);
    req_valid = req_valid & ~taken;
    guard++;
  end
  if (req_valid != '0) begin
    errors++;
    $display("request mask 0x%0h was never accepted by the fabric", req_valid);
    req_valid = '0;
  end
endtask

task automatic send_req(input int m, input logic [ADDR_W-1:0] addr,
                        input logic [ID_W-1:0] id, output int accept_cycle);
  @(negedge clock);
  set_req(m, addr, id);
  wait_accepted(accept_cycle);
endtask

task automatic wait_rsp(input int n);
  int guard;
  guard = 0;
  while (rsp_log.size() < n && guard < 50) begin
    @(negedge clock);
    guard++;
  end
  if (rsp_log.size() < n) begin
    errors++;
    $display("timed out waiting for response number %0d", n);
  end
  repeat (3) @(negedge clock); // room for a stray beat to show up
endtask

task automatic check_rsp(input int idx, input int mst, input logic [DATA_W-1:0] data,
                         input logic [RESP_W-1:0] resp, input logic [ID_W-1:0] id);
  check_value("rsp master", mst, rsp_mst[idx]);
  check_value("rsp.data", data, rsp_log[idx].data);
  check_value("rsp.resp", resp, rsp_log[idx].resp);
  check_value("rsp.last", 1, rsp_log[idx].last);
  check_value("rsp.id", id, rsp_log[idx].id);
endtask

task automatic check_ar(input int idx, input logic [ADDR_W-1:0] addr,
                        input logic [ID_W-1:0] id);
  check_value("ext_ar.addr", addr, ar_log[idx].addr);
  check_value("ext_ar.id", id, ar_log[idx].id);
endtask

task automatic test_reset();
  repeat (2) begin
    @(posedge clock);
    check_value("rsp_valid", 0, rsp_valid);
    check_value("ext_ar_valid", 0, ext_ar_valid);
  end
  @(negedge clock);
  rst_n = 1'b1;
  repeat (2) begin
    @(posedge clock);
    check_value("rsp_valid", 0, rsp_valid);
    check_value("ext_ar_valid", 0, ext_ar_valid);
  end
endtask

task automatic test_ext_read();
  int cyc;
  clear_logs();
  send_req(0, 32'h8000_1234, 4'h5, cyc);
  wait_rsp(1);
  check_value("ext_ar transfers", 1, ar_log.size());
  check_ar(0, 32'h8000_1234, 4'h5);
  check_value("rsp count", 1, rsp_log.size()); // load master stays silent
  check_rsp(0, 0, 32'h8000_1234 ^ MEM_XOR, RESP_OKAY, 4'h5);
endtask

task automatic test_timer_reads();
  int c_first;
  int c_second;
  int c_hi;
  clear_logs();
  send_req(1, CLINT_BASE + MTIME_LO_OFF, 4'h2, c_first);
  wait_rsp(1);
  send_req(1, CLINT_BASE + MTIME_LO_OFF, 4'h3, c_second);
  wait_rsp(2);
  send_req(1, CLINT_BASE + MTIME_HI_OFF, 4'h4, c_hi);
  wait_rsp(3);
  check_value("ext_ar transfers", 0, ar_log.size());
  check_value("rsp count", 3, rsp_log.size());
  check_value("rsp master", 1, rsp_mst[0]);
  check_value("rsp master", 1, rsp_mst[1]);
  check_value("rsp.id", 4'h2, rsp_log[0].id);
  check_value("rsp.id", 4'h3, rsp_log[1].id);
  check_value("rsp.resp", RESP_OKAY, rsp_log[0].resp);
  check_value("rsp.resp", RESP_OKAY, rsp_log[1].resp);
  // mtime advances at least one tick per cycle between the two reads
  check_value("mtime_lo rising", 1, rsp_log[1].data > rsp_log[0].data);
  check_value("mtime_lo step", 1,
              (rsp_log[1].data - rsp_log[0].data) >= 32'(c_second - c_first));
  check_rsp(2, 1, '0, RESP_OKAY, 4'h4);
endtask

task automatic test_unmapped_offset();
  int cyc;
  clear_logs();
  send_req(1, CLINT_BASE + 32'h10, 4'h7, cyc);
  wait_rsp(1);
  check_value("ext_ar transfers", 0, ar_log.size());
  check_rsp(0, 1, '0, RESP_DECERR, 4'h7);
endtask

task automatic test_contention();
  int cyc;
  clear_logs();
  @(negedge clock);
  set_req(0, 32'h8000_0100, 4'h1);
  set_req(1, 32'h8000_0200, 4'h9);
  wait_accepted(cyc);
  wait_rsp(2);
  check_value("ext_ar transfers", 2, ar_log.size());
  check_ar(0, 32'h8000_0200, 4'h9); // load goes first
  check_ar(1, 32'h8000_0100, 4'h1);
  check_rsp(0, 1, 32'h8000_0200 ^ MEM_XOR, RESP_OKAY, 4'h9);
  check_rsp(1, 0, 32'h8000_0100 ^ MEM_XOR, RESP_OKAY, 4'h1);
endtask

task automatic test_ar_backpressure();
  int cyc;
  clear_logs();
  @(negedge clock);
  ar_open = 1'b0;
  send_req(0, 32'h8000_2000, 4'h6, cyc);
  repeat (5) begin
    @(posedge clock);
    check_value("ext_ar_valid", 1, ext_ar_valid);
    check_value("ext_ar.addr", 32'h8000_2000, ext_ar.addr);
    check_value("ext_ar.id", 4'h6, ext_ar.id);
  end
  @(negedge clock);
  ar_open = 1'b1;
  wait_rsp(1);
  check_value("ext_ar transfers", 1, ar_log.size());
  check_rsp(0, 0, 32'h8000_2000 ^ MEM_XOR, RESP_OKAY, 4'h6);
endtask

task automatic test_rsp_backpressure();
  int cyc;
  int guard;
  guard = 0;
  clear_logs();
  @(negedge clock);
  rsp_ready = '0;
  send_req(0, 32'h8000_3000, 4'hc, cyc);
  do begin
    @(posedge clock);
    guard++;
  end while (!rsp_valid[0] && guard < 20);
  repeat (4) begin
    @(posedge clock);
    check_value("rsp_valid", 1, rsp_valid[0]);
    check_value("rsp.data", 32'h8000_3000 ^ MEM_XOR, rsp[0].data);
    check_value("rsp.id", 4'hc, rsp[0].id);
    check_value("ext_r_ready", 0, ext_r_ready); // memory beat stays parked
  end
  @(negedge clock);
  rsp_ready = '1;
  wait_rsp(1);
  check_value("rsp count", 1, rsp_log.size());
  check_rsp(0, 0, 32'h8000_3000 ^ MEM_XOR, RESP_OKAY, 4'hc);
endtask

// ==== tests/fabric_tb.sv ====
module fabric_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import bus_pkg::*;

  localparam int                N_TESTS         = 7;
  localparam int                WATCHDOG_CYCLES = N_TESTS * 200 + 100;
  localparam logic [DATA_W-1:0] MEM_XOR         = 32'ha5a5_5a5a;

  logic                 clock;
  logic                 rst_n;
  logic [N_MASTERS-1:0] req_valid;
  logic [N_MASTERS-1:0] req_ready;
  rd_req_t              req [N_MASTERS];
  logic [N_MASTERS-1:0] rsp_valid;
  logic [N_MASTERS-1:0] rsp_ready;
  rd_rsp_t              rsp [N_MASTERS];
  logic                 ext_ar_valid;
  logic                 ext_ar_ready;
  rd_req_t              ext_ar;
  logic                 ext_r_valid;
  logic                 ext_r_ready;
  rd_rsp_t              ext_r;

  logic   ar_open;    // test gate on ext_ar_ready
  logic   mem_busy;   // memory model holds a read
  integer seed      = 13;
  int     cycle_cnt = 0;
  int     errors    = 0;
  int     checks    = 0;

  // transfers seen at the rising edge
  rd_req_t ar_log [$];
  rd_rsp_t rsp_log [$];
  int      rsp_mst [$];

  assign ext_ar_ready = ar_open && !mem_busy;

  read_fabric read_fabric_i (.*);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_cnt <= cycle_cnt + 1;
    if (rst_n) begin
      if (ext_ar_valid && ext_ar_ready) begin
        ar_log.push_back(ext_ar);
      end
      for (int m = 0; m < N_MASTERS; m++) begin
        if (rsp_valid[m] && rsp_ready[m]) begin
          rsp_log.push_back(rsp[m]);
          rsp_mst.push_back(m);
        end
      end
    end
  end

  // external memory, one read at a time, 0 to 3 cycles late
  initial begin : ext_memory
    rd_req_t pending;
    int      delay;
    mem_busy    = 1'b0;
    ext_r_valid = 1'b0;
    ext_r       = '0;
    forever begin
      @(posedge clock);
      if (rst_n && ext_ar_valid && ext_ar_ready) begin
        pending = ext_ar;
        delay   = $random(seed) & 3;
        @(negedge clock);
        mem_busy = 1'b1;
        repeat (delay) @(negedge clock);
        ext_r.data  = pending.addr ^ MEM_XOR;
        ext_r.resp  = RESP_OKAY;
        ext_r.last  = 1'b1;
        ext_r.id    = pending.id;
        ext_r_valid = 1'b1;
        do begin
          @(posedge clock);
        end while (!ext_r_ready);
        @(negedge clock);
        ext_r_valid = 1'b0;
        mem_busy    = 1'b0;
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  `include "fabric_tests.svh"

  initial begin
    rst_n     = 1'b0;
    req_valid = '0;
    rsp_ready = '1;
    ar_open   = 1'b1;
    for (int m = 0; m < N_MASTERS; m++) begin
      req[m] = '0;
    end
    test_reset();
    test_ext_read();
    test_timer_reads();
    test_unmapped_offset();
    test_contention();
    test_ar_backpressure();
    test_rsp_backpressure();
    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+tests
logic/bus_pkg.sv
logic/hold_slice.sv
logic/read_arbiter.sv
logic/clint_timer.sv
logic/read_fabric.sv
tests/fabric_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module fabric_tb -Mdir obj_dir -f build.f

./obj_dir/Vfabric_tb > sim.log 2>&1
cat sim.log

if grep -qx "TEST PASSED" sim.log; then
  exit 0
else
  exit 1
fi
